// ==== all.f ====
+incdir+common
common/discrete_pkg.sv
rtl/audio_clk_enable.sv
rtl/vco_ctrl_regs.sv
vco_555/natural_log.sv
vco_555/astable_555_vco.sv
rtl/rc_lowpass.sv
rtl/discrete_555_top.sv
sim/tb_discrete_555.sv

// ==== common/discrete_cfg.svh ====
`ifndef DISCRETE_CFG_SVH
`define DISCRETE_CFG_SVH

// System clock, Hz
`define CLOCK_RATE 50000000

// Audio sample rate, Hz
`define SAMPLE_RATE 48000

// Astable timing network
//
//   VCC --R1--+--R2--+-- threshold/trigger
//             |      |
//         discharge  C
//                    |
//                   gnd
//
// High phase charges C through R1+R2 up to the control voltage
// Low phase discharges C through R2 only
`define R1_OHMS 47000
`define R2_OHMS 27000

// Capacitor in farads times 2^35, 33 nF
`define C_35_SHIFTED 1134

// Supply level in 16-bit control units
// Kept slightly above 2^15 so VCC - v never hits zero
`define VCC_LEVEL 32770

// Guard band below VCC for the control clamp
`define VCC_MARGIN 64

// Low-pass shift right after reset
`define FILT_SHIFT_RESET 4

`endif

// ==== common/discrete_pkg.sv ====
`default_nettype none

package discrete_pkg;

    // Audio sample or control voltage, 16-bit
    typedef logic [15:0] sample_t;

    // Logarithm result, 4 integer + 8 fraction bits
    typedef logic [11:0] ln_t;

    // Log argument, 16 integer + 8 fraction bits, never below 1.0
    typedef logic [23:0] lnarg_t;

    // Count of system clocks
    typedef logic [31:0] cycles_t;

    // Register map
    typedef enum logic [1:0] {
        REG_VCTRL  = 2'd0, // Control voltage
        REG_CTRL   = 2'd1, // Bit 0 run, bits 3:1 filter shift
        REG_STATUS = 2'd2  // Bit 0 current output level
    } reg_addr_t;

    // Square wave levels
    localparam sample_t LEVEL_HIGH = 16'h8000;
    localparam sample_t LEVEL_LOW  = 16'h0000;

endpackage

`default_nettype wire

// ==== rtl/audio_clk_enable.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "discrete_cfg.svh"

// Sample strobe from a fractional phase accumulator
// Adds SAMPLE_RATE per clock, fires when CLOCK_RATE is reached
module audio_clk_enable (
    input  wire  clk,
    input  wire  arst_n,
    output logic audio_clk_en
);
    import discrete_pkg::*;

    localparam cycles_t STEP = cycles_t'(`SAMPLE_RATE);
    localparam cycles_t WRAP = cycles_t'(`CLOCK_RATE);

    cycles_t phase_acc; // Always below WRAP
    cycles_t phase_sum;
    logic    phase_hit;

    // Sum never overflows, both rates fit well under 2^31
    assign phase_sum = phase_acc + STEP;
    assign phase_hit = (phase_sum >= WRAP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_acc    <= '0;
            audio_clk_en <= 1'b0;
        end else begin
            if (phase_hit) begin
                phase_acc <= phase_sum - WRAP; // Keep remainder, no drift
            end else begin
                phase_acc <= phase_sum;
            end
            audio_clk_en <= phase_hit; // One clock wide
        end
    end

endmodule

`default_nettype wire

// ==== rtl/discrete_555_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// 555 VCO voice with register control and output smoothing
module discrete_555_top (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     reg_wr,
    input  discrete_pkg::reg_addr_t reg_addr,
    input  discrete_pkg::sample_t   reg_wdata,
    output discrete_pkg::sample_t   reg_rdata,
    output logic                    audio_clk_en,
    output discrete_pkg::sample_t   vco_out,
    output discrete_pkg::sample_t   filt_out
);
    import discrete_pkg::*;

    sample_t    v_control;
    logic       run;
    logic [2:0] filt_shift;

    audio_clk_enable u_audio_clk_enable (
        .clk          (clk),
        .arst_n       (arst_n),
        .audio_clk_en (audio_clk_en)
    );

    vco_ctrl_regs u_vco_ctrl_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .v_control  (v_control),
        .run        (run),
        .filt_shift (filt_shift),
        .vco_level  (vco_out)     // Status readback
    );

    astable_555_vco u_astable_555_vco (
        .clk          (clk),
        .arst_n       (arst_n),
        .audio_clk_en (audio_clk_en),
        .run          (run),
        .v_control    (v_control),
        .out          (vco_out)
    );

    rc_lowpass u_rc_lowpass (
        .clk          (clk),
        .arst_n       (arst_n),
        .audio_clk_en (audio_clk_en),
        .filt_shift   (filt_shift),
        .in           (vco_out),
        .out          (filt_out)
    );

endmodule

`default_nettype wire

// ==== rtl/rc_lowpass.sv ====
`timescale 1ns/100ps
`default_nettype none

// First-order RC model, y += (x - y) >>> shift on each strobe
// Samples are unsigned, so 16'h8000 counts as +32768
module rc_lowpass (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   audio_clk_en,
    input  wire  [2:0]            filt_shift,
    input  discrete_pkg::sample_t in,
    output discrete_pkg::sample_t out
);
    import discrete_pkg::*;

    logic [31:0]        state;  // 16 integer + 16 fraction bits
    logic signed [32:0] diff;   // Target minus state
    logic signed [32:0] step;
    logic signed [32:0] next_state;

    always_comb begin
        diff       = $signed({1'b0, in, 16'd0}) - $signed({1'b0, state});
        step       = diff >>> filt_shift; // Larger shift, slower corner
        next_state = $signed({1'b0, state}) + step;
    end

    // Next state stays between old state and target, no overflow
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= '0;
        end else if (audio_clk_en) begin
            state <= next_state[31:0];
        end
    end

    assign out = sample_t'(state[31:16]); // Fraction bits dropped

endmodule

`default_nettype wire

// ==== rtl/vco_ctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "discrete_cfg.svh"

// Settings for the oscillator and its output filter
module vco_ctrl_regs (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    reg_wr,
    input  discrete_pkg::reg_addr_t reg_addr,
    input  discrete_pkg::sample_t   reg_wdata,
    output discrete_pkg::sample_t   reg_rdata,
    output discrete_pkg::sample_t   v_control,
    output logic                   run,
    output logic [2:0]             filt_shift,
    input  discrete_pkg::sample_t   vco_level
);
    import discrete_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_control  <= '0;
            run        <= 1'b0; // Timer held in reset
            filt_shift <= 3'(`FILT_SHIFT_RESET);
        end else if (reg_wr) begin
            case (reg_addr)
                REG_VCTRL: begin
                    v_control <= reg_wdata;
                end
                REG_CTRL: begin
                    run        <= reg_wdata[0];
                    filt_shift <= reg_wdata[3:1];
                end
                default: begin
                    // Status is read only
                end
            endcase
        end
    end

    // Readback, combinational on address
    always_comb begin
        case (reg_addr)
            REG_VCTRL:  reg_rdata = v_control;
            REG_CTRL:   reg_rdata = {12'd0, filt_shift, run};
            REG_STATUS: reg_rdata = {15'd0, vco_level[15]}; // Live output level
            default:    reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_discrete_555 -Mdir obj_dir -o tb_discrete_555 > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_discrete_555 > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== sim/tb_discrete_555.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "discrete_cfg.svh"

module tb_discrete_555;
    import discrete_pkg::*;

    // Rows of control voltage, filter shift, run bit, strobes to observe
    localparam int NUM_ROWS = 4;
    localparam int TBL_V     [NUM_ROWS] = '{16384, 24576, 20480, 20480};
    localparam int TBL_SHIFT [NUM_ROWS] = '{4, 2, 2, 4};
    localparam int TBL_RUN   [NUM_ROWS] = '{1, 1, 0, 1};
    localparam int TBL_N     [NUM_ROWS] = '{300, 450, 100, 320};

    logic      clk;
    logic      arst_n;
    logic      reg_wr;
    reg_addr_t reg_addr;
    sample_t   reg_wdata;
    sample_t   reg_rdata;
    logic      audio_clk_en;
    sample_t   vco_out;
    sample_t   filt_out;

    int unsigned checks;
    int unsigned errors;
    logic [31:0] rng_state;
    int          row_id;          // Row being applied, -1 before the first
    int          row_samples;     // Strobes seen since the row's readback
    longint      clk_count;       // Clocks since reset release
    longint      strobe_count;
    logic        count_started;
    int          model_shift;     // Register contents as the DUT should hold them
    logic        model_run;
    logic        strobe_pending;  // Strobe edge just passed
    logic        edge_run;        // Run bit at the last strobe edge
    logic        last_edge_run;
    longint      ref_state;       // Reference filter, 16 fraction bits
    logic        cur_lvl;
    int          run_len;
    int          run_row;         // Row in which the current level started
    int          row_high_len    [NUM_ROWS];
    int          row_high_checks [NUM_ROWS];
    int          row_low_checks  [NUM_ROWS];
    logic        row_high_seen   [NUM_ROWS];
    longint      cycle_count;
    longint      cycle_limit;

    discrete_555_top u_discrete_555_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .audio_clk_en (audio_clk_en),
        .vco_out      (vco_out),
        .filt_out     (filt_out)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic real cap_farads();
        return real'(`C_35_SHIFTED) / (2.0 ** 35);
    endfunction

    // Discharge from 2/3 to 1/3 through R2
    function automatic real low_samples();
        return cap_farads() * real'(`R2_OHMS) * $ln(2.0) * real'(`SAMPLE_RATE);
    endfunction

    // Charge through R1+R2 up to the control voltage
    function automatic real high_samples(input int v);
        real ratio;
        real tau;
        ratio = real'(v) / (2.0 * real'(`VCC_LEVEL - v));
        tau   = cap_farads() * real'(`R1_OHMS + `R2_OHMS);
        return tau * $ln(1.0 + ratio) * real'(`SAMPLE_RATE);
    endfunction

    function automatic longint timeout_cycles();
        longint total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += TBL_N[i];
        end
        return total * `CLOCK_RATE / `SAMPLE_RATE * 11 / 10 + NUM_ROWS * 200 + 100;
    endfunction

    task automatic write_reg(input reg_addr_t addr, input sample_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0; // Latched on this edge
    endtask

    // At least 4 idle clocks so the log pipeline settles before run rises
    task automatic idle_gap();
        int n;
        rng_state = xorshift(rng_state);
        n = 4 + int'(rng_state[2:0]);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_readback(input reg_addr_t addr, input sample_t expected);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        checks++;
        assert (reg_rdata == expected) else begin
            errors++;
            $display("Mismatch at %0t: register %0d reads %h, expected %h",
                     $time, addr, reg_rdata, expected);
        end
    endtask

    // Length check of a finished level run
    task automatic phase_done(input logic lvl, input int len);
        real expected;
        real tol;
        if (TBL_RUN[row_id] == 0) begin
            return;
        end
        if (lvl) begin
            if (!row_high_seen[row_id]) begin
                row_high_seen[row_id] = 1'b1; // May still carry the previous voltage
                return;
            end
            expected = high_samples(TBL_V[row_id]);
            tol      = 1.0 + 0.03 * expected;
            row_high_len[row_id] = len;
            row_high_checks[row_id]++;
        end else begin
            expected = low_samples();
            tol      = 1.0 + 0.02 * expected;
            row_low_checks[row_id]++;
        end
        checks++;
        assert (real'(len) - expected <= tol && expected - real'(len) <= tol) else begin
            errors++;
            $display("Mismatch at %0t: %s phase spans %0d samples, expected %0.2f",
                     $time, lvl ? "high" : "low", len, expected);
        end
    endtask

    // Called on the negedge after a strobe edge, new outputs are settled
    task automatic sample_done();
        row_samples++;
        checks++;
        assert (vco_out == 16'h8000 || vco_out == 16'h0000) else begin
            errors++;
            $display("Mismatch at %0t: vco_out %h is not a square wave level", $time, vco_out);
        end
        checks++;
        assert (filt_out == 16'(ref_state >>> 16)) else begin
            errors++;
            $display("Mismatch at %0t: filt_out %h, reference %h",
                     $time, filt_out, 16'(ref_state >>> 16));
        end
        if (!edge_run) begin
            checks++;
            assert (vco_out == 16'h0000) else begin
                errors++;
                $display("Mismatch at %0t: vco_out %h with run cleared", $time, vco_out);
            end
        end else if (!last_edge_run) begin
            checks++;
            assert (vco_out == 16'h8000) else begin
                errors++;
                $display("Mismatch at %0t: first phase after run set is low", $time);
            end
        end
        last_edge_run = edge_run;
        if (vco_out[15] == cur_lvl) begin
            run_len++;
        end else begin
            if (row_id >= 0 && run_row == row_id) begin
                phase_done(cur_lvl, run_len); // Both ends inside one row
            end
            cur_lvl = vco_out[15];
            run_len = 1;
            run_row = row_id;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            checks++;
            assert (vco_out == 16'h0000 && filt_out == 16'h0000 && !audio_clk_en) else begin
                errors++;
                $display("Mismatch at %0t: outputs not zero in reset", $time);
            end
        end else begin
            if (count_started) begin
                clk_count++;
            end
            count_started = 1'b1;
            if (strobe_pending) begin
                sample_done();
            end
            strobe_pending = audio_clk_en;
            if (audio_clk_en) begin
                strobe_count++;
                edge_run  = model_run;
                ref_state = ref_state + ((longint'(vco_out) * 65536 - ref_state) >>> model_shift);
            end
            if (reg_addr == REG_STATUS) begin
                checks++;
                assert (reg_rdata == {15'd0, vco_out[15]}) else begin
                    errors++;
                    $display("Mismatch at %0t: status %h, vco_out %h", $time, reg_rdata, vco_out);
                end
            end
            if (reg_wr && reg_addr == REG_CTRL) begin
                model_run   = reg_wdata[0]; // Takes effect after the coming edge
                model_shift = int'(reg_wdata[3:1]);
            end
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        cycle_limit = timeout_cycles();
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, row %0d never finished", cycle_count, row_id);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        sample_t ctrl_word;
        arst_n         = 1'b0;
        reg_wr         = 1'b0;
        reg_addr       = REG_STATUS;
        reg_wdata      = '0;
        checks         = 0;
        errors         = 0;
        rng_state      = 32'ha7dd;
        row_id         = -1;
        row_samples    = 0;
        clk_count      = 0;
        strobe_count   = 0;
        count_started  = 1'b0;
        model_shift    = `FILT_SHIFT_RESET;
        model_run      = 1'b0;
        strobe_pending = 1'b0;
        edge_run       = 1'b0;
        last_edge_run  = 1'b0;
        ref_state      = 0;
        cur_lvl        = 1'b0;
        run_len        = 0;
        run_row        = -1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_high_len[i]    = 0;
            row_high_checks[i] = 0;
            row_low_checks[i]  = 0;
            row_high_seen[i]   = 1'b0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            row_id    = r;
            ctrl_word = {12'd0, 3'(TBL_SHIFT[r]), 1'(TBL_RUN[r])};
            write_reg(REG_VCTRL, sample_t'(TBL_V[r]));
            idle_gap();
            write_reg(REG_CTRL, ctrl_word);
            check_readback(REG_VCTRL, sample_t'(TBL_V[r]));
            check_readback(REG_CTRL, ctrl_word);
            @(posedge clk);
            reg_addr    <= REG_STATUS; // Status is watched for the whole row
            row_samples = 0;
            while (row_samples < TBL_N[r]) begin
                @(posedge clk);
            end
            checks++;
            assert (strobe_count == clk_count * `SAMPLE_RATE / `CLOCK_RATE) else begin
                errors++;
                $display("Mismatch at %0t: %0d strobes in %0d clocks",
                         $time, strobe_count, clk_count);
            end
            if (TBL_RUN[r] != 0) begin
                checks++;
                assert (row_high_checks[r] > 0 && row_low_checks[r] > 0) else begin
                    errors++;
                    $display("Row %0d ended without a complete high and low phase", r);
                end
            end
        end

        // Higher control voltage must give a longer high phase
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int j = 0; j < NUM_ROWS; j++) begin
                if (TBL_RUN[i] != 0 && TBL_RUN[j] != 0 && TBL_V[i] > TBL_V[j]) begin
                    checks++;
                    assert (row_high_len[i] > row_high_len[j]) else begin
                        errors++;
                        $display("Mismatch at %0t: high phase %0d at v %0d vs %0d at v %0d",
                                 $time, row_high_len[i], TBL_V[i], row_high_len[j], TBL_V[j]);
                    end
                end
            end
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vco_555/astable_555_vco.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "discrete_cfg.svh"

// 555 astable, control pin driven
//   t_high = C*(R1+R2)*ln(1 + v/(2*(VCC-v)))
//   t_low  = C*R2*ln2
// Both phases counted in system clocks, sampled on the audio strobe
module astable_555_vco (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   audio_clk_en,
    input  wire                   run,
    input  discrete_pkg::sample_t v_control,
    output discrete_pkg::sample_t out
);
    import discrete_pkg::*;

    localparam longint unsigned C35    = `C_35_SHIFTED;
    localparam longint unsigned R1     = `R1_OHMS;
    localparam longint unsigned R2     = `R2_OHMS;
    localparam longint unsigned CLK_HZ = `CLOCK_RATE;
    localparam longint unsigned LN2_16 = 45426;

    // Charge time constant in clocks, 8 fraction bits
    localparam longint unsigned TAU_HIGH_8 = (C35 * (R1 + R2) * CLK_HZ) >> 27;
    // Discharge time constant in clocks, 16 fraction bits
    localparam longint unsigned TAU_LOW_16 = (C35 * R2 * CLK_HZ) >> 19;
    localparam cycles_t CYCLES_LOW = cycles_t'((TAU_LOW_16 * LN2_16) >> 32);

    localparam sample_t V_MAX = sample_t'(`VCC_LEVEL - `VCC_MARGIN);
    localparam logic [16:0] VCC = 17'(`VCC_LEVEL);

    sample_t       v_clamped;
    logic [16:0]   v_den;        // 2*(VCC - v)
    logic [23:0]   v_ratio_8;    // v/(2*(VCC - v)), 8 fraction bits
    lnarg_t        lnarg_q;
    ln_t           ln_8;
    logic [63:0]   high_prod;
    cycles_t       cycles_high;  // Pipelined from the control voltage
    cycles_t       high_len;     // Length used by the current period
    cycles_t       period_last;
    cycles_t       cnt;

    // Clamp keeps the divisor above zero
    assign v_clamped = (v_control > V_MAX) ? V_MAX : v_control;
    assign v_den     = (VCC - {1'b0, v_clamped}) << 1;
    assign v_ratio_8 = {v_clamped, 8'd0} / 24'(v_den);

    always_ff @(posedge clk) begin
        lnarg_q <= 24'd256 + v_ratio_8; // 1.0 + ratio
    end

    natural_log u_natural_log (
        .clk           (clk),
        .in_8_shifted  (lnarg_q),
        .out_8_shifted (ln_8)
    );

    assign high_prod = TAU_HIGH_8 * 64'(ln_8);

    always_ff @(posedge clk) begin
        cycles_high <= cycles_t'(high_prod >> 16); // Drop 16 fraction bits
    end

    assign period_last = high_len + CYCLES_LOW - 32'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            high_len <= '0;
            out      <= LEVEL_LOW;
        end else begin
            if (!run) begin
                cnt      <= '0;           // Timer reset pin low
                high_len <= cycles_high;  // Track so restart uses the latest value
            end else if (cnt >= period_last) begin
                cnt      <= '0;
                high_len <= cycles_high;  // New length from the wrap on
            end else begin
                cnt <= cnt + 32'd1;
            end

            if (audio_clk_en) begin
                out <= (run && (cnt < high_len)) ? LEVEL_HIGH : LEVEL_LOW;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vco_555/natural_log.sv ====
`timescale 1ns/100ps
`default_nettype none

// Natural log of an 8-fraction-bit value >= 1.0
// ln(x) = e*ln2 + ln(1.m), e from the leading one, ln(1.m) from a table
// Two clocks latency, one argument per clock
module natural_log (
    input  wire                  clk,
    input  discrete_pkg::lnarg_t in_8_shifted,
    output discrete_pkg::ln_t    out_8_shifted
);
    import discrete_pkg::*;

    localparam logic [20:0] LN2_16 = 21'd45426; // ln2 * 2^16

    // ln(1 + i/16) * 2^16, i = 0..15
    function automatic logic [15:0] ln_table(input logic [3:0] idx);
        case (idx)
            4'd0:    ln_table = 16'd0;
            4'd1:    ln_table = 16'd3973;
            4'd2:    ln_table = 16'd7719;
            4'd3:    ln_table = 16'd11262;
            4'd4:    ln_table = 16'd14624;
            4'd5:    ln_table = 16'd17821;
            4'd6:    ln_table = 16'd20870;
            4'd7:    ln_table = 16'd23783;
            4'd8:    ln_table = 16'd26572;
            4'd9:    ln_table = 16'd29248;
            4'd10:   ln_table = 16'd31818;
            4'd11:   ln_table = 16'd34291;
            4'd12:   ln_table = 16'd36675;
            4'd13:   ln_table = 16'd38975;
            4'd14:   ln_table = 16'd41196;
            default: ln_table = 16'd43345;
        endcase
    endfunction

    logic [4:0]  lead_pos;   // Leading one bit index, 8..23
    lnarg_t      norm;       // Leading one moved to bit 23
    logic [3:0]  exp_q;      // Integer log2
    logic [3:0]  idx_q;      // Top mantissa bits
    logic [7:0]  interp_q;   // Next mantissa bits
    logic [15:0] tab_lo;
    logic [15:0] tab_hi;
    logic [16:0] tab_diff;
    logic [24:0] tab_step;
    logic [20:0] ln_sum_16;

    // Stage 1 leading one detect, below 1.0 treated as 1.0
    always_comb begin
        lead_pos = 5'd8;
        for (int i = 9; i < 24; i++) begin
            if (in_8_shifted[i]) lead_pos = 5'(i);
        end
        norm = in_8_shifted << (5'd23 - lead_pos);
    end

    always_ff @(posedge clk) begin
        exp_q    <= 4'(lead_pos - 5'd8);
        idx_q    <= norm[22:19];
        interp_q <= norm[18:11];
    end

    // Stage 2 table lookup with linear interpolation
    always_comb begin
        tab_lo = ln_table(idx_q);
        if (idx_q == 4'd15) begin
            tab_hi = LN2_16[15:0]; // ln(2) closes the segment
        end else begin
            tab_hi = ln_table(idx_q + 4'd1);
        end
        tab_diff  = {1'b0, tab_hi} - {1'b0, tab_lo}; // Table is rising
        tab_step  = tab_diff * interp_q;
        ln_sum_16 = 21'(exp_q) * LN2_16 + 21'(tab_lo) + 21'(tab_step[24:8]);
    end

    always_ff @(posedge clk) begin
        out_8_shifted <= ln_t'((ln_sum_16 + 21'd128) >> 8); // Round to 8 fraction bits
    end

endmodule

`default_nettype wire
